/* project.f */
verilog/vdp_pkg.sv
verilog/vram_pkg.sv
verilog/vram_array.sv
verilog/vram_request_queue.sv
verilog/vdp_port_decoder.sv
verilog/vdp_cart_top.sv
bench/vdp_cart_checker.sv
bench/tb_vdp_cart.sv

/* Bender.yml */
package:
  name: vdp_cart

sources:
  # RTL, packages first
  - files:
      - verilog/vdp_pkg.sv
      - verilog/vram_pkg.sv
      - verilog/vram_array.sv
      - verilog/vram_request_queue.sv
      - verilog/vdp_port_decoder.sv
      - verilog/vdp_cart_top.sv
  # Testbench and bound checker
  - target: test
    files:
      - bench/vdp_cart_checker.sv
      - bench/tb_vdp_cart.sv

/* bench/tb_vdp_cart.sv */
// Single host, one port cycle at a time; VRAM is compared only where the bench wrote it
`timescale 1ns/1ps
module tb_vdp_cart import vdp_pkg::*, vram_pkg::*; ();
	localparam int ACK_TIMEOUT	= 200;		// Cycles allowed per host cycle
	localparam int SEED			= 72;

	logic							clk;
	logic							w_n_reset;
	logic							bus_req;
	logic							bus_wr;
	vdp_port_e						bus_address;
	logic	[7:0]					bus_wdata;
	logic							bus_ack;
	logic							bus_wait;
	logic	[7:0]					bus_rdata;

	// Shadow state
	logic	[7:0]					reg_model [CTRL_REG_COUNT];
	logic	[7:0]					vram_model [VRAM_BYTES];
	logic	[VRAM_ADDR_BITS-1:0]	addr_model;		// Next byte port 0 touches
	int								checks;
	int								errors;
	int								tests;
	int								errs_before;	// Error count at test start

	vdp_cart_top vdp_cart_top_inst (
		.clk			(clk),
		.w_n_reset		(w_n_reset),
		.bus_req		(bus_req),
		.bus_wr			(bus_wr),
		.bus_address	(bus_address),
		.bus_wdata		(bus_wdata),
		.bus_ack		(bus_ack),
		.bus_wait		(bus_wait),
		.bus_rdata		(bus_rdata)
	);

	bind vdp_port_decoder vdp_cart_checker checker_inst (
		.clk			(clk),
		.w_n_reset		(w_n_reset),
		.bus_req		(bus_req),
		.bus_ack		(bus_ack),
		.bus_wait		(bus_wait),
		.op_valid		(op_valid),
		.credit_return	(credit_return),
		.credit_cnt		(credit_cnt)
	);

	always #20 clk = ~clk;		// 40 ns period

	// --------------------------------------------------
	// Host port cycles
	// --------------------------------------------------
	task automatic host_cycle(input vdp_port_e port, input logic wr, input logic [7:0] wdata,
			output logic [7:0] rdata);
		int waited;
		waited = 0;
		@(posedge clk);
		#2;
		bus_req		= 1'b1;		// One-cycle request
		bus_wr		= wr;
		bus_address	= port;
		bus_wdata	= wdata;
		@(posedge clk);
		#2;
		bus_req = 1'b0;
		while (!bus_ack && waited < ACK_TIMEOUT) begin
			@(posedge clk);
			#2;
			waited++;
		end
		if (!bus_ack) begin
			$display("%s %s cycle never completed, no bus_ack after %0d cycles",
				port.name(), wr ? "write" : "read", ACK_TIMEOUT);
			$display("TEST FAILED");
			$finish;
		end else begin
			rdata = bus_rdata;		// Valid in the ack cycle
		end
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		checks++;
		assert (got === exp) else begin
			$display("error at time %0t: %s read %02h, expected %02h", $time, what, got, exp);
			errors++;
		end
	endtask

	// Two-byte port-1 register write, indices of 32 or more dropped
	task automatic reg_write(input int idx, input logic [7:0] value);
		logic [7:0] unused;
		host_cycle(PORT_CTRL, 1'b1, value, unused);
		host_cycle(PORT_CTRL, 1'b1, {2'b10, idx[5:0]}, unused);
		if (idx < CTRL_REG_COUNT) reg_model[idx] = value;
	endtask

	// Point R15 at idx, then a port-1 read
	task automatic reg_check(input int idx);
		logic [7:0] got;
		reg_write(STATUS_PTR_REG, 8'(idx));
		host_cycle(PORT_CTRL, 1'b0, 8'h00, got);
		check_byte(got, reg_model[idx], $sformatf("R%0d", idx));
	endtask

	task automatic indirect_write(input logic [7:0] value);
		logic [7:0]	unused;
		logic [5:0]	idx;
		logic		hold;
		idx		= reg_model[INDIRECT_PTR_REG][5:0];
		hold	= reg_model[INDIRECT_PTR_REG][7];		// Bit 7 stops the increment
		host_cycle(PORT_INDIRECT, 1'b1, value, unused);
		if (idx < CTRL_REG_COUNT) reg_model[idx] = value;
		if (!hold) reg_model[INDIRECT_PTR_REG][5:0] = idx + 1'b1;
	endtask

	task automatic vram_setup(input logic [VRAM_ADDR_BITS-1:0] addr, input logic for_write);
		logic [7:0] unused;
		host_cycle(PORT_CTRL, 1'b1, addr[7:0], unused);
		host_cycle(PORT_CTRL, 1'b1, {1'b0, for_write, addr[VRAM_ADDR_BITS-1:8]}, unused);
		addr_model = addr;
	endtask

	task automatic vram_write(input logic [7:0] value);
		logic [7:0] unused;
		host_cycle(PORT_VRAM, 1'b1, value, unused);
		vram_model[addr_model] = value;
		addr_model++;
	endtask

	task automatic vram_read_check();
		logic [7:0] got;
		host_cycle(PORT_VRAM, 1'b0, 8'h00, got);
		check_byte(got, vram_model[addr_model], $sformatf("VRAM %04h", addr_model));
		addr_model++;
	endtask

	task automatic finish_test(input string name);
		tests++;
		$display("test %0d %s done, %0d errors", tests, name, errors - errs_before);
		errs_before = errors;
	endtask

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial begin
		logic [VRAM_ADDR_BITS-1:0]	base;
		logic [7:0]					unused;
		clk			= 1'b0;
		w_n_reset	= 1'b0;
		bus_req		= 1'b0;
		bus_wr		= 1'b0;
		bus_address	= PORT_VRAM;
		bus_wdata	= 8'h00;
		checks		= 0;
		errors		= 0;
		tests		= 0;
		errs_before	= 0;
		addr_model	= '0;
		void'($urandom(SEED));
		for (int i = 0; i < CTRL_REG_COUNT; i++) reg_model[i] = 8'h00;		// Reset value
		repeat (5) @(posedge clk);
		#2;
		w_n_reset = 1'b1;

		for (int i = 0; i < CTRL_REG_COUNT; i++) begin
			reg_write(i, 8'($urandom));
			reg_check(i);
		end
		for (int i = 0; i < 8; i++) begin
			reg_write(CTRL_REG_COUNT + int'($urandom_range(31)), 8'($urandom));	// Dropped
		end
		for (int i = 0; i < CTRL_REG_COUNT; i++) reg_check(i);
		finish_test("register write and read-back");

		reg_write(INDIRECT_PTR_REG, 8'd20);
		repeat (5) indirect_write(8'($urandom));
		for (int i = 20; i < 25; i++) reg_check(i);
		reg_check(INDIRECT_PTR_REG);			// Pointer now at 25
		reg_write(INDIRECT_PTR_REG, 8'h88);	// Held on R8
		repeat (3) indirect_write(8'($urandom));
		reg_check(8);
		reg_check(9);
		reg_check(INDIRECT_PTR_REG);
		finish_test("indirect register writes");

		base = 14'h12F0;		// Stream crosses into row 0x13
		vram_setup(base, 1'b1);
		repeat (48) vram_write(8'($urandom));
		vram_setup(base, 1'b0);
		repeat (48) vram_read_check();
		finish_test("VRAM write then read");

		// Every write lands in the other row, so each one misses
		for (int i = 0; i < 16; i++) begin
			vram_setup(14'h2000 + 14'(i), 1'b1);
			vram_write(8'($urandom));
			vram_setup(14'h3400 + 14'(i), 1'b1);
			vram_write(8'($urandom));
		end
		vram_setup(14'h2000, 1'b0);
		repeat (16) vram_read_check();
		vram_setup(14'h3400, 1'b0);
		repeat (16) vram_read_check();
		// Unbroken stream over two row boundaries, the queue fills and credits run out
		vram_setup(14'h20FE, 1'b1);
		repeat (300) vram_write(8'($urandom));
		vram_setup(14'h20FE, 1'b0);
		repeat (300) vram_read_check();
		finish_test("row-miss burst");

		vram_setup(base, 1'b1);		// A stray VRAM write would land on base
		repeat (4) host_cycle(PORT_PALETTE, 1'b1, 8'($urandom), unused);
		for (int i = 0; i < CTRL_REG_COUNT; i++) reg_check(i);
		vram_setup(base, 1'b0);
		repeat (8) vram_read_check();
		finish_test("palette writes ignored");

		$display("tests %0d, checks %0d, errors %0d, assertion failures %0d", tests, checks,
			errors, vdp_cart_top_inst.decoder_inst.checker_inst.fail_count);
		if (errors == 0 && vdp_cart_top_inst.decoder_inst.checker_inst.fail_count == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* bench/vdp_cart_checker.sv */
// Handshake and credit rules of the decoder; assumes one host request outstanding at a time
`timescale 1ns/1ps
module vdp_cart_checker import vram_pkg::*; (
	input	logic						clk,
	input	logic						w_n_reset,
	input	logic						bus_req,
	input	logic						bus_ack,
	input	logic						bus_wait,
	input	logic						op_valid,
	input	logic						credit_return,
	input	logic	[CREDIT_BITS-1:0]	credit_cnt
);
	int							fail_count = 0;
	logic						req_open;		// Request seen, ack not yet
	logic	[CREDIT_BITS-1:0]	in_flight;		// Ops sent whose credit is not back yet

	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			req_open	<= 1'b0;
			in_flight	<= '0;
		end else begin
			req_open	<= (req_open && !bus_ack) || bus_req;
			in_flight	<= in_flight + CREDIT_BITS'(op_valid) - CREDIT_BITS'(credit_return);
		end
	end

	// --------------------------------------------------
	// Host handshake
	// --------------------------------------------------
	ack_has_req: assert property (@(posedge clk) disable iff (!w_n_reset) bus_ack |-> req_open)
		else begin
			$error("bus_ack without an outstanding request");
			fail_count++;
		end
	wait_held: assert property (@(posedge clk) disable iff (!w_n_reset) req_open |-> bus_wait)
		else begin
			$error("bus_wait low while a request is outstanding");
			fail_count++;
		end
	wait_drops: assert property (@(posedge clk) disable iff (!w_n_reset) bus_ack |=> !bus_wait)
		else begin
			$error("bus_wait still high the cycle after bus_ack");
			fail_count++;
		end

	// --------------------------------------------------
	// Credits
	// --------------------------------------------------
	credit_cap: assert property (@(posedge clk) disable iff (!w_n_reset)
		credit_cnt <= VRAM_CREDITS)
		else begin
			$error("credit count above the queue depth");
			fail_count++;
		end
	// Each new op needs a queue slot not yet claimed by earlier ones
	issue_has_credit: assert property (@(posedge clk) disable iff (!w_n_reset)
		op_valid |-> (in_flight < VRAM_CREDITS))
		else begin
			$error("op_valid issued without a credit");
			fail_count++;
		end

endmodule

/* verilog/vdp_cart_top.sv */
// Register and VRAM access path only; no video timing, sprites, commands or interrupts
`timescale 1ns/1ps
module vdp_cart_top import vdp_pkg::*, vram_pkg::*; (
	input	logic			clk,
	input	logic			w_n_reset,
	input	logic			bus_req,
	input	logic			bus_wr,
	input	vdp_port_e		bus_address,
	input	logic	[7:0]	bus_wdata,
	output	logic			bus_ack,
	output	logic			bus_wait,		// Cartridge wait line
	output	logic	[7:0]	bus_rdata
);
	// Decoder to queue
	logic							op_valid;
	vram_op_e						op_code;
	logic	[VRAM_ADDR_BITS-1:0]	op_address;
	logic	[7:0]					op_wdata;
	logic							credit_return;
	// Queue to array
	logic							mem_valid;
	vram_op_e						mem_code;
	logic	[VRAM_ADDR_BITS-1:0]	mem_address;
	logic	[7:0]					mem_wdata;
	logic							mem_idle;
	// Read return to prefetch latch
	logic							rd_valid;
	logic	[7:0]					rd_data;

	// --------------------------------------------------
	// Stage 1, host port decoder
	// --------------------------------------------------
	vdp_port_decoder decoder_inst (.*);

	// --------------------------------------------------
	// Stage 2, credit queue
	// --------------------------------------------------
	vram_request_queue queue_inst (.*);

	// --------------------------------------------------
	// Stage 3, VRAM with row latency
	// --------------------------------------------------
	vram_array array_inst (.*);

endmodule

/* verilog/vdp_port_decoder.sv */
// One host cycle at a time; a port-0 read right after a write setup waits for a read setup
`timescale 1ns/1ps
module vdp_port_decoder import vdp_pkg::*, vram_pkg::*; (
	input	logic						clk,
	input	logic						w_n_reset,
	input	logic						bus_req,
	input	logic						bus_wr,
	input	vdp_port_e					bus_address,
	input	logic	[7:0]				bus_wdata,
	output	logic						bus_ack,
	output	logic						bus_wait,
	output	logic	[7:0]				bus_rdata,
	output	logic						op_valid,
	output	vram_op_e					op_code,
	output	logic	[VRAM_ADDR_BITS-1:0]	op_address,
	output	logic	[7:0]				op_wdata,
	input	logic						credit_return,
	input	logic						rd_valid,
	input	logic	[7:0]				rd_data
);
	typedef enum logic [1:0] {ST_IDLE, ST_WR_WAIT, ST_RD_WAIT} state_e;

	state_e							state;
	logic							ctrl_second;		// Next port-1 byte is the second
	logic	[7:0]					ctrl_first;
	logic	[7:0]					ctrl_regs [CTRL_REG_COUNT];
	logic	[VRAM_ADDR_BITS-1:0]	vram_ptr;
	logic	[7:0]					pf_data;			// Prefetch latch
	logic							pf_valid;
	logic							pf_pend;			// Prefetch still to be issued
	logic	[CREDIT_BITS-1:0]		credit_cnt;
	logic	[CREDIT_BITS-1:0]		rd_out;				// Reads in flight
	logic	[CREDIT_BITS-1:0]		rd_skip;			// Stale reads to drop
	logic	[7:0]					hold_data;
	logic	[7:0]					wr_byte;
	logic	[5:0]					ind_idx;
	logic	[CTRL_REG_BITS-1:0]		status_idx;
	logic							can_issue, host_vram, ctrl_req;
	logic							wr_go, rd_go, pf_go, issue, pf_load;

	// --------------------------------------------------
	// Issue decisions
	// --------------------------------------------------
	assign can_issue	= (credit_cnt != '0) || credit_return;	// Returned credit usable at once
	assign host_vram	= (state == ST_IDLE) && bus_req && (bus_address == PORT_VRAM);
	assign ctrl_req		= (state == ST_IDLE) && bus_req && (bus_address != PORT_VRAM);
	assign pf_go		= pf_pend && can_issue;		// Setup prefetch goes first, keeps order
	assign wr_go		= !pf_pend && can_issue && ((host_vram && bus_wr) || (state == ST_WR_WAIT));
	assign rd_go		= !pf_pend && can_issue && pf_valid &&
						  ((host_vram && !bus_wr) || (state == ST_RD_WAIT));
	assign issue		= wr_go || rd_go || pf_go;
	assign pf_load		= rd_valid && (rd_skip == '0);
	assign wr_byte		= (state == ST_WR_WAIT) ? hold_data : bus_wdata;
	assign ind_idx		= ctrl_regs[INDIRECT_PTR_REG][5:0];
	assign status_idx	= ctrl_regs[STATUS_PTR_REG][CTRL_REG_BITS-1:0];

	// --------------------------------------------------
	// Control state
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			state		<= ST_IDLE;
			bus_ack		<= 1'b0;
			bus_wait	<= 1'b0;
			op_valid	<= 1'b0;
			ctrl_second	<= 1'b0;
			vram_ptr	<= '0;
			pf_valid	<= 1'b0;
			pf_pend		<= 1'b0;
			credit_cnt	<= CREDIT_BITS'(VRAM_CREDITS);
			rd_out		<= '0;
			rd_skip		<= '0;
			for (int i = 0; i < CTRL_REG_COUNT; i++) begin
				ctrl_regs[i] <= '0;
			end
		end else begin
			bus_ack		<= ctrl_req || wr_go || rd_go;
			op_valid	<= issue;
			credit_cnt	<= credit_cnt - CREDIT_BITS'(issue) + CREDIT_BITS'(credit_return);
			rd_out		<= rd_out + CREDIT_BITS'(rd_go || pf_go) - CREDIT_BITS'(rd_valid);
			if (bus_ack) begin
				bus_wait <= 1'b0;		// Drops the cycle after ack
			end else if (bus_req) begin
				bus_wait <= 1'b1;
			end
			case (state)
				ST_IDLE: begin
					if (host_vram && bus_wr && !wr_go) begin
						state <= ST_WR_WAIT;	// Out of credits
					end else if (host_vram && !bus_wr && !rd_go) begin
						state <= ST_RD_WAIT;	// Latch empty or no credit
					end
				end
				ST_WR_WAIT: if (wr_go) state <= ST_IDLE;
				ST_RD_WAIT: if (rd_go) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
			if (rd_valid && (rd_skip != '0)) rd_skip <= rd_skip - 1'b1;
			if (rd_go) begin
				pf_valid <= 1'b0;
			end else if (pf_load) begin
				pf_valid <= 1'b1;
			end
			if (issue) vram_ptr <= vram_ptr + 1'b1;
			if (pf_go) pf_pend <= 1'b0;
			// Register side, always one-cycle ack
			if (ctrl_req) begin
				case (bus_address)
					PORT_CTRL: begin
						if (!bus_wr) begin
							ctrl_second <= 1'b0;		// Read restarts the sequence
						end else if (!ctrl_second) begin
							ctrl_second <= 1'b1;
						end else begin
							ctrl_second <= 1'b0;
							if (bus_wdata[7]) begin
								if (bus_wdata[5:0] < CTRL_REG_COUNT) begin
									ctrl_regs[bus_wdata[CTRL_REG_BITS-1:0]] <= ctrl_first;
								end
							end else begin
								vram_ptr <= {bus_wdata[VRAM_ADDR_BITS-9:0], ctrl_first};
								if (!bus_wdata[6]) begin
									pf_pend		<= 1'b1;	// Read setup
									pf_valid	<= 1'b0;
									// Everything still in flight belongs to the old address
									rd_skip <= rd_out + CREDIT_BITS'(pf_go) - CREDIT_BITS'(rd_valid);
								end
							end
						end
					end
					PORT_INDIRECT: begin
						if (bus_wr) begin
							if (ind_idx < CTRL_REG_COUNT) begin
								ctrl_regs[ind_idx[CTRL_REG_BITS-1:0]] <= bus_wdata;
							end
							if (!ctrl_regs[INDIRECT_PTR_REG][7]) begin
								ctrl_regs[INDIRECT_PTR_REG][5:0] <= ind_idx + 1'b1;
							end
						end
					end
					default: ;		// Palette, ack only
				endcase
			end
		end
	end

	// --------------------------------------------------
	// Data path
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (issue) begin
			op_code		<= wr_go ? OP_WRITE : OP_READ;
			op_address	<= vram_ptr;
			op_wdata	<= wr_byte;
		end
		if (host_vram && bus_wr) hold_data <= bus_wdata;	// Kept while waiting on credit
		if (ctrl_req && (bus_address == PORT_CTRL) && bus_wr && !ctrl_second) begin
			ctrl_first <= bus_wdata;
		end
		if (pf_load) pf_data <= rd_data;
		if (rd_go) begin
			bus_rdata <= pf_data;
		end else if (ctrl_req) begin
			bus_rdata <= (bus_address == PORT_CTRL) ? ctrl_regs[status_idx] : 8'h00;
		end
	end

endmodule

/* verilog/vram_request_queue.sv */
// Depth equals the credit count and must be a power of two; relies on the sender never overrunning
`timescale 1ns/1ps
module vram_request_queue import vdp_pkg::*, vram_pkg::*; (
	input	logic						clk,
	input	logic						w_n_reset,
	input	logic						op_valid,
	input	vram_op_e					op_code,
	input	logic	[VRAM_ADDR_BITS-1:0]	op_address,
	input	logic	[7:0]				op_wdata,
	output	logic						credit_return,
	output	logic						mem_valid,
	output	vram_op_e					mem_code,
	output	logic	[VRAM_ADDR_BITS-1:0]	mem_address,
	output	logic	[7:0]				mem_wdata,
	input	logic						mem_idle
);
	// --------------------------------------------------
	// Entry storage
	// --------------------------------------------------
	vram_op_e						q_code [VRAM_CREDITS];
	logic	[VRAM_ADDR_BITS-1:0]	q_addr [VRAM_CREDITS];
	logic	[7:0]					q_data [VRAM_CREDITS];

	logic	[QUEUE_PTR_BITS-1:0]	wr_ptr;		// Wraps on its own
	logic	[QUEUE_PTR_BITS-1:0]	rd_ptr;
	logic	[CREDIT_BITS-1:0]		fill;
	logic							pop;

	// Head leaves as soon as the array is free
	assign pop				= (fill != '0) && mem_idle;
	assign mem_valid		= pop;
	assign credit_return	= pop;		// One credit per departing entry

	// Head of queue straight to the array
	assign mem_code		= q_code[rd_ptr];
	assign mem_address	= q_addr[rd_ptr];
	assign mem_wdata	= q_data[rd_ptr];

	// --------------------------------------------------
	// Pointers and fill count
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			wr_ptr	<= '0;
			rd_ptr	<= '0;
			fill	<= '0;
		end else begin
			if (op_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			fill <= fill + CREDIT_BITS'(op_valid) - CREDIT_BITS'(pop);
		end
	end

	// Push side
	always_ff @(posedge clk) begin
		if (op_valid) begin
			q_code[wr_ptr]	<= op_code;
			q_addr[wr_ptr]	<= op_address;
			q_data[wr_ptr]	<= op_wdata;
		end
	end

endmodule

/* verilog/vram_array.sv */
// Behavioural 16 KB VRAM; one operation at a time, latency set by the open 256-byte row
`timescale 1ns/1ps
module vram_array import vdp_pkg::*, vram_pkg::*; (
	input	logic						clk,
	input	logic						w_n_reset,
	input	logic						mem_valid,
	input	vram_op_e					mem_code,
	input	logic	[VRAM_ADDR_BITS-1:0]	mem_address,
	input	logic	[7:0]				mem_wdata,
	output	logic						mem_idle,
	output	logic						rd_valid,
	output	logic	[7:0]				rd_data
);
	logic	[7:0]					mem [VRAM_BYTES];
	logic							busy;
	logic	[LAT_BITS-1:0]			lat_cnt;		// Counts down to completion
	logic							row_valid;
	logic	[VRAM_ROW_BITS-1:0]		open_row;
	logic	[VRAM_ROW_BITS-1:0]		req_row;
	vram_op_e						cur_code;
	logic	[VRAM_ADDR_BITS-1:0]	cur_addr;
	logic	[7:0]					cur_data;
	logic							hit, done;

	assign req_row	= mem_address[VRAM_ADDR_BITS-1 -: VRAM_ROW_BITS];
	assign hit		= row_valid && (req_row == open_row);
	assign done		= busy && (lat_cnt == '0);
	assign mem_idle	= !busy;

	// --------------------------------------------------
	// Latency and open row
	// --------------------------------------------------
	always_ff @(posedge clk) begin
		if (!w_n_reset) begin
			busy		<= 1'b0;
			lat_cnt		<= '0;
			row_valid	<= 1'b0;		// No row open
			open_row	<= '0;
			rd_valid	<= 1'b0;
		end else begin
			rd_valid <= done && (cur_code == OP_READ);
			if (mem_valid) begin
				busy	<= 1'b1;
				// Minus the accept and the completion cycles
				lat_cnt	<= hit ? LAT_BITS'(ROW_HIT_CYCLES - 2) : LAT_BITS'(ROW_MISS_CYCLES - 2);
			end else if (done) begin
				busy		<= 1'b0;
				row_valid	<= 1'b1;
				open_row	<= cur_addr[VRAM_ADDR_BITS-1 -: VRAM_ROW_BITS];
			end else if (busy) begin
				lat_cnt <= lat_cnt - 1'b1;
			end
		end
	end

	// Operation latch and storage
	always_ff @(posedge clk) begin
		if (mem_valid) begin
			cur_code	<= mem_code;
			cur_addr	<= mem_address;
			cur_data	<= mem_wdata;
		end
		if (done) begin
			if (cur_code == OP_WRITE) mem[cur_addr] <= cur_data;
			rd_data <= mem[cur_addr];		// Only looked at on reads
		end
	end

endmodule

/* verilog/vram_pkg.sv */
// Memory side only; 14-bit address space and a power-of-two queue depth are assumed
package vram_pkg;

	// Address space, cut down from the 17 bits of a real V9958
	localparam int VRAM_ADDR_BITS	= 14;
	localparam int VRAM_BYTES		= 1 << VRAM_ADDR_BITS;	// 16 KB
	localparam int VRAM_ROW_BITS	= 6;	// Upper bits, 256-byte rows

	// Flow control between decoder and queue
	localparam int VRAM_CREDITS		= 4;	// Queue depth too
	localparam int CREDIT_BITS		= $clog2(VRAM_CREDITS + 1);
	localparam int QUEUE_PTR_BITS	= $clog2(VRAM_CREDITS);

	// --------------------------------------------------
	// Array latency, request to completion
	// --------------------------------------------------
	localparam int ROW_HIT_CYCLES	= 2;
	localparam int ROW_MISS_CYCLES	= 5;
	localparam int LAT_BITS			= $clog2(ROW_MISS_CYCLES);

endpackage

/* verilog/vdp_pkg.sv */
// Host side only; port numbers follow the V9958 I/O map, register indices of 32 or more dropped
package vdp_pkg;

	// --------------------------------------------------
	// Host ports, selected by the two address lines
	// --------------------------------------------------
	typedef enum logic [1:0] {
		PORT_VRAM		= 2'd0,		// VRAM data with auto increment
		PORT_CTRL		= 2'd1,		// Two-byte control sequence
		PORT_PALETTE	= 2'd2,		// Palette, no storage here
		PORT_INDIRECT	= 2'd3		// Register write through R17
	} vdp_port_e;

	// --------------------------------------------------
	// VRAM operations carried down the pipeline
	// --------------------------------------------------
	typedef enum logic {
		OP_READ		= 1'b0,
		OP_WRITE	= 1'b1
	} vram_op_e;

	// Control register file
	localparam int CTRL_REG_COUNT	= 32;
	localparam int CTRL_REG_BITS	= 5;	// Index width

	// Pointer registers
	localparam int STATUS_PTR_REG	= 15;	// Selects the register a port-1 read returns
	localparam int INDIRECT_PTR_REG	= 17;	// Port-3 target, bit 7 stops the increment

endpackage
